// ==== mipsCpu_params.svh ====
`ifndef MIPS_CPU_PARAMS_SVH
`define MIPS_CPU_PARAMS_SVH

// Boot address loaded into the PC on reset
// Matches the usual MIPS boot ROM location in kseg1
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Fetch address that ends a program
// Reached by a JR through a register holding zero
`define MIPS_HALT_ADDR 32'h0000_0000

// Index of v0, the return value register
`define MIPS_REG_V0 5'd2

// Number of general purpose registers
`define MIPS_NUM_REGS 32

`endif

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

  // Basic vector types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // Operation selected by the decoder for the ALU
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI, ALU_MULTU, ALU_MFHI, ALU_MFLO,
    ALU_BEQ, ALU_BNE,
    ALU_PASS
  } aluOp_t;

  // Primary opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0A;
  localparam opcode_t OP_ANDI  = 6'h0C;
  localparam opcode_t OP_ORI   = 6'h0D;
  localparam opcode_t OP_XORI  = 6'h0E;
  localparam opcode_t OP_LUI   = 6'h0F;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2B;

  // R-type function codes
  localparam funct_t FN_SLL   = 6'h00;
  localparam funct_t FN_SRL   = 6'h02;
  localparam funct_t FN_SRA   = 6'h03;
  localparam funct_t FN_JR    = 6'h08;
  localparam funct_t FN_MFHI  = 6'h10;
  localparam funct_t FN_MFLO  = 6'h12;
  localparam funct_t FN_MULTU = 6'h19;
  localparam funct_t FN_ADDU  = 6'h21;
  localparam funct_t FN_SUBU  = 6'h23;
  localparam funct_t FN_AND   = 6'h24;
  localparam funct_t FN_OR    = 6'h25;
  localparam funct_t FN_XOR   = 6'h26;
  localparam funct_t FN_NOR   = 6'h27;
  localparam funct_t FN_SLT   = 6'h2A;
  localparam funct_t FN_SLTU  = 6'h2B;

endpackage

`default_nettype wire

// ==== programCounter.sv ====
`default_nettype none

`include "mipsCpu_params.svh"

module programCounter (
  input  logic           clk,
  input  logic           reset,
  input  logic           clk_enable,
  input  logic           jump,
  input  logic           jumpReg,
  input  logic           takeBranch,
  input  mipsPkg::word_t rsData,
  input  logic [25:0]    jumpTarget,
  input  logic [15:0]    branchOffset,
  output mipsPkg::word_t pc,
  output logic           active
);
  import mipsPkg::*;

  word_t pcPlus4;
  word_t branchTarget;
  word_t jumpAddr;
  word_t nextPc;
  logic  atHalt;

  // Sequential successor
  assign pcPlus4 = pc + 32'd4;

  // Word offset, sign-extended, relative to the following instruction
  assign branchTarget = pcPlus4 + {{14{branchOffset[15]}}, branchOffset, 2'b00};

  // Pseudo-direct target stays inside the current 256 MB region
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  assign atHalt = (pc == `MIPS_HALT_ADDR);

  // Register jump beats direct jump beats branch
  always_comb
  begin
    if (jumpReg)
      nextPc = rsData;
    else if (jump)
      nextPc = jumpAddr;
    else if (takeBranch)
      nextPc = branchTarget;
    else
      nextPc = pcPlus4;
  end

  // PC advances only on enabled edges while the core still runs
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc     <= `MIPS_RESET_VECTOR;
      active <= 1'b1;
    end
    else if (clk_enable && active)
    begin
      // Park at the halt address and drop active on the next edge
      if (atHalt)
        active <= 1'b0;
      else
        pc <= nextPc;
    end
  end

  // A JR through a misaligned register would break fetch alignment
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("PC not word-aligned: %h", pc);

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`default_nettype none

module controlUnit (
  input  mipsPkg::opcode_t opcode,
  input  mipsPkg::funct_t  funct,
  output logic             regWrite,
  output logic             regDst,
  output logic             aluSrcImm,
  output logic             memToReg,
  output logic             zeroExtend,
  output logic             jump,
  output logic             jumpReg,
  output logic             data_read,
  output logic             data_write,
  output mipsPkg::aluOp_t  aluOp
);
  import mipsPkg::*;

  always_comb
  begin
    // Everything off by default, so unknown encodings act as a NOP
    regWrite   = 1'b0;
    regDst     = 1'b0;
    aluSrcImm  = 1'b0;
    memToReg   = 1'b0;
    zeroExtend = 1'b0;
    jump       = 1'b0;
    jumpReg    = 1'b0;
    data_read  = 1'b0;
    data_write = 1'b0;
    aluOp      = ALU_PASS;

    case (opcode)
      OP_RTYPE:
      begin
        // Most R-type ops write rd
        regDst = 1'b1;
        case (funct)
          FN_ADDU:  begin regWrite = 1'b1; aluOp = ALU_ADD;  end
          FN_SUBU:  begin regWrite = 1'b1; aluOp = ALU_SUB;  end
          FN_AND:   begin regWrite = 1'b1; aluOp = ALU_AND;  end
          FN_OR:    begin regWrite = 1'b1; aluOp = ALU_OR;   end
          FN_XOR:   begin regWrite = 1'b1; aluOp = ALU_XOR;  end
          FN_NOR:   begin regWrite = 1'b1; aluOp = ALU_NOR;  end
          FN_SLT:   begin regWrite = 1'b1; aluOp = ALU_SLT;  end
          FN_SLTU:  begin regWrite = 1'b1; aluOp = ALU_SLTU; end
          FN_SLL:   begin regWrite = 1'b1; aluOp = ALU_SLL;  end
          FN_SRL:   begin regWrite = 1'b1; aluOp = ALU_SRL;  end
          FN_SRA:   begin regWrite = 1'b1; aluOp = ALU_SRA;  end
          FN_MFHI:  begin regWrite = 1'b1; aluOp = ALU_MFHI; end
          FN_MFLO:  begin regWrite = 1'b1; aluOp = ALU_MFLO; end
          // Product goes to HI/LO only
          FN_MULTU: aluOp = ALU_MULTU;
          FN_JR:    jumpReg = 1'b1;
          default:  regDst = 1'b0;
        endcase
      end
      // Arithmetic immediates sign-extend
      OP_ADDIU: begin regWrite = 1'b1; aluSrcImm = 1'b1; aluOp = ALU_ADD; end
      OP_SLTI:  begin regWrite = 1'b1; aluSrcImm = 1'b1; aluOp = ALU_SLT; end
      // Logic immediates zero-extend
      OP_ANDI:
      begin
        regWrite = 1'b1; aluSrcImm = 1'b1; zeroExtend = 1'b1; aluOp = ALU_AND;
      end
      OP_ORI:
      begin
        regWrite = 1'b1; aluSrcImm = 1'b1; zeroExtend = 1'b1; aluOp = ALU_OR;
      end
      OP_XORI:
      begin
        regWrite = 1'b1; aluSrcImm = 1'b1; zeroExtend = 1'b1; aluOp = ALU_XOR;
      end
      OP_LUI:   begin regWrite = 1'b1; aluSrcImm = 1'b1; aluOp = ALU_LUI; end
      // Address is base plus signed offset
      OP_LW:
      begin
        regWrite = 1'b1; aluSrcImm = 1'b1; memToReg = 1'b1; data_read = 1'b1;
        aluOp = ALU_ADD;
      end
      OP_SW:    begin aluSrcImm = 1'b1; data_write = 1'b1; aluOp = ALU_ADD; end
      OP_BEQ:   aluOp = ALU_BEQ;
      OP_BNE:   aluOp = ALU_BNE;
      OP_J:     jump = 1'b1;
      default:  aluOp = ALU_PASS;
    endcase

    // No encoding may both read and write data memory
    assert (!(data_read && data_write))
      else $error("Decoder drives data_read and data_write together");
  end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`default_nettype none

`include "mipsCpu_params.svh"

module registerFile (
  input  logic             clk,
  input  logic             reset,
  input  logic             clk_enable,
  input  logic             regWrite,
  input  mipsPkg::regIdx_t readReg1,
  input  mipsPkg::regIdx_t readReg2,
  input  mipsPkg::regIdx_t writeReg,
  input  mipsPkg::word_t   writeData,
  output mipsPkg::word_t   readData1,
  output mipsPkg::word_t   readData2,
  output mipsPkg::word_t   register_v0
);
  import mipsPkg::*;

  // General purpose registers
  word_t regs [`MIPS_NUM_REGS];
  logic  writeEn;

  // Writes to r0 are dropped here, so r0 stays at its reset value of zero
  assign writeEn = clk_enable && regWrite && (writeReg != '0);

  // Asynchronous read ports
  assign readData1 = regs[readReg1];
  assign readData2 = regs[readReg2];

  // Return value register exported for observation
  assign register_v0 = regs[`MIPS_REG_V0];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeEn)
    begin
      regs[writeReg] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  input  logic            aluSrcImm,
  input  logic            zeroExtend,
  input  mipsPkg::aluOp_t aluOp,
  input  mipsPkg::word_t  rsData,
  input  mipsPkg::word_t  rtData,
  input  logic [15:0]     immediate,
  input  logic [4:0]      shamt,
  output mipsPkg::word_t  aluResult,
  output logic            takeBranch
);
  import mipsPkg::*;

  word_t       extImm;
  word_t       opB;
  word_t       hi;
  word_t       lo;
  logic [63:0] product;
  logic        operandsEqual;

  // Logic immediates zero-extend and everything else sign-extends
  assign extImm = zeroExtend ? {16'h0000, immediate}
                             : {{16{immediate[15]}}, immediate};

  // Second operand
  assign opB = aluSrcImm ? extImm : rtData;

  // Full unsigned 64-bit product for MULTU
  assign product = {32'h0, rsData} * {32'h0, rtData};

  // Branches always compare rs with rt
  assign operandsEqual = (rsData == rtData);

  always_comb
  begin
    case (aluOp)
      ALU_ADD:  aluResult = rsData + opB;
      ALU_SUB:  aluResult = rsData - opB;
      ALU_AND:  aluResult = rsData & opB;
      ALU_OR:   aluResult = rsData | opB;
      ALU_XOR:  aluResult = rsData ^ opB;
      ALU_NOR:  aluResult = ~(rsData | opB);
      // Signed compare for SLT and SLTI
      ALU_SLT:  aluResult = {31'h0, $signed(rsData) < $signed(opB)};
      ALU_SLTU: aluResult = {31'h0, rsData < opB};
      // Shifts act on rt by the shamt field
      ALU_SLL:  aluResult = rtData << shamt;
      ALU_SRL:  aluResult = rtData >> shamt;
      ALU_SRA:  aluResult = word_t'($signed(rtData) >>> shamt);
      // Immediate into the upper half, lower half cleared
      ALU_LUI:  aluResult = {immediate, 16'h0000};
      ALU_MFHI: aluResult = hi;
      ALU_MFLO: aluResult = lo;
      // Difference of the compared operands, not written back
      ALU_BEQ,
      ALU_BNE:  aluResult = rsData - rtData;
      ALU_MULTU: aluResult = '0;
      default:  aluResult = opB;
    endcase
  end

  // Branch decision
  always_comb
  begin
    case (aluOp)
      ALU_BEQ: takeBranch = operandsEqual;
      ALU_BNE: takeBranch = !operandsEqual;
      default: takeBranch = 1'b0;
    endcase
  end

  // HI/LO pair, loaded by MULTU on an enabled edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (clk_enable && aluOp == ALU_MULTU)
    begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

endmodule

`default_nettype wire

// ==== mipsCpuHarvard.sv ====
`default_nettype none

module mipsCpuHarvard (
  input  logic           clk,
  input  logic           reset,
  input  logic           clk_enable,
  output logic           active,
  output mipsPkg::word_t register_v0,
  // Instruction port, combinational read
  output mipsPkg::word_t instr_address,
  input  mipsPkg::word_t instr_readdata,
  // Data port, combinational read and single-cycle write
  output mipsPkg::word_t data_address,
  output logic           data_write,
  output logic           data_read,
  output mipsPkg::word_t data_writedata,
  input  mipsPkg::word_t data_readdata
);
  import mipsPkg::*;

  // Instruction fields
  opcode_t     opcode;
  regIdx_t     rs;
  regIdx_t     rt;
  regIdx_t     rd;
  logic [4:0]  shamt;
  funct_t      funct;
  logic [15:0] immediate;
  logic [25:0] jumpTarget;

  // Decoder outputs
  logic   regWrite;
  logic   regDst;
  logic   aluSrcImm;
  logic   memToReg;
  logic   zeroExtend;
  logic   jump;
  logic   jumpReg;
  aluOp_t aluOp;

  // Datapath
  word_t   rsData;
  word_t   rtData;
  word_t   aluResult;
  word_t   writeData;
  regIdx_t writeReg;
  logic    takeBranch;

  // Field split
  assign opcode     = instr_readdata[31:26];
  assign rs         = instr_readdata[25:21];
  assign rt         = instr_readdata[20:16];
  assign rd         = instr_readdata[15:11];
  assign shamt      = instr_readdata[10:6];
  assign funct      = instr_readdata[5:0];
  assign immediate  = instr_readdata[15:0];
  assign jumpTarget = instr_readdata[25:0];

  // R-type writes rd, immediates and loads write rt
  assign writeReg  = regDst ? rd : rt;
  assign writeData = memToReg ? data_readdata : aluResult;

  // Effective address and store data
  assign data_address   = aluResult;
  assign data_writedata = rtData;

  programCounter pcUnit (
    .clk(clk), .reset(reset), .clk_enable(clk_enable),
    .jump(jump), .jumpReg(jumpReg), .takeBranch(takeBranch),
    .rsData(rsData), .jumpTarget(jumpTarget), .branchOffset(immediate),
    .pc(instr_address), .active(active)
  );

  controlUnit decoder (
    .opcode(opcode), .funct(funct),
    .regWrite(regWrite), .regDst(regDst), .aluSrcImm(aluSrcImm),
    .memToReg(memToReg), .zeroExtend(zeroExtend), .jump(jump), .jumpReg(jumpReg),
    .data_read(data_read), .data_write(data_write), .aluOp(aluOp)
  );

  registerFile regFile (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .regWrite(regWrite),
    .readReg1(rs), .readReg2(rt), .writeReg(writeReg), .writeData(writeData),
    .readData1(rsData), .readData2(rtData), .register_v0(register_v0)
  );

  alu aluUnit (
    .clk(clk), .reset(reset), .clk_enable(clk_enable),
    .aluSrcImm(aluSrcImm), .zeroExtend(zeroExtend), .aluOp(aluOp),
    .rsData(rsData), .rtData(rtData), .immediate(immediate), .shamt(shamt),
    .aluResult(aluResult), .takeBranch(takeBranch)
  );

endmodule

`default_nettype wire

// ==== tbMemory.sv ====
`default_nettype none

`include "mipsCpu_params.svh"

module tbMemory #(
  parameter mipsPkg::word_t ramBase = 32'h0000_1000
) (
  input  logic           clk,
  input  logic           clk_enable,
  // Instruction side
  input  mipsPkg::word_t instr_address,
  output mipsPkg::word_t instr_readdata,
  // Data side
  input  mipsPkg::word_t data_address,
  input  logic           data_write,
  input  logic           data_read,
  input  mipsPkg::word_t data_writedata,
  output mipsPkg::word_t data_readdata,
  // Program loading and RAM inspection from the testbench
  input  logic           loadEn,
  input  logic [3:0]     loadIndex,
  input  mipsPkg::word_t loadWord,
  input  logic           clearRam,
  input  mipsPkg::word_t peekAddress,
  output mipsPkg::word_t peekData
);
  timeunit 1ns;
  timeprecision 100ps;
  import mipsPkg::*;

  localparam word_t romBase = `MIPS_RESET_VECTOR;

  // 16-word program ROM at the reset vector, 64-word data RAM
  word_t rom [16];
  word_t ram [64];
  logic  romHit;
  logic  dataHit;
  logic  peekHit;

  // Window decodes use the whole address, so stray accesses never alias
  assign romHit  = (instr_address[31:6] == romBase[31:6]);
  assign dataHit = (data_address[31:8] == ramBase[31:8]);
  assign peekHit = (peekAddress[31:8] == ramBase[31:8]);

  // Outside the ROM window the fetch sees a NOP, address 0 included
  assign instr_readdata = romHit ? rom[instr_address[5:2]] : '0;
  assign data_readdata  = (data_read && dataHit) ? ram[data_address[7:2]] : '0;
  assign peekData       = peekHit ? ram[peekAddress[7:2]] : '0;

  always @(posedge clk)
  begin
    if (clearRam)
    begin
      for (int i = 0; i < 64; i++)
      begin
        ram[i] <= '0;
      end
    end
    else if (data_write && clk_enable && dataHit)
    begin
      ram[data_address[7:2]] <= data_writedata;
    end
    // One ROM word per edge while loading
    if (loadEn)
      rom[loadIndex] <= loadWord;
  end

endmodule

`default_nettype wire

// ==== mipsCpuTb.sv ====
`default_nettype none

`include "mipsCpu_params.svh"

module mipsCpuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import mipsPkg::*;

  localparam int numTests = 10;
  localparam int maxWords = 16;
  localparam int resetCycles = 16;
  // Reset and up to four cycles per program word for each row plus a margin
  localparam int timeoutCycles = numTests * (resetCycles + 4 * maxWords) + 200;
  localparam word_t seed = 32'h48ce_8dd7;
  localparam word_t dataBase = 32'h0000_1000;

  localparam regIdx_t regZero = 5'd0;
  localparam regIdx_t regV0 = `MIPS_REG_V0;
  localparam regIdx_t regT0 = 5'd8;
  localparam regIdx_t regT1 = 5'd9;
  localparam regIdx_t regT2 = 5'd10;
  localparam regIdx_t regT3 = 5'd11;

  // DUT ports
  logic  clk = 1'b0;
  logic  reset;
  logic  clk_enable;
  logic  active;
  word_t register_v0;
  word_t instr_address;
  word_t instr_readdata;
  word_t data_address;
  word_t data_writedata;
  word_t data_readdata;
  logic  data_write;
  logic  data_read;

  // Memory loading and inspection
  logic       loadEn;
  logic [3:0] loadIndex;
  word_t      loadWord;
  logic       clearRam;
  word_t      peekAddress;
  word_t      peekData;

  // Test table, one row per program
  word_t programs   [numTests][maxWords];
  int    progLen    [numTests];
  logic  stallEn    [numTests];
  word_t expectedV0 [numTests];
  logic  ramCheck   [numTests];
  word_t ramAddr    [numTests];
  word_t ramValue   [numTests];

  word_t rngState;
  int    errorCount;
  int    checkCount;
  int    cycleCount = 0;

  always #5 clk = ~clk;

  mipsCpuHarvard i_mipsCpuHarvard (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
    .register_v0(register_v0),
    .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  tbMemory #(.ramBase(dataBase)) i_mem (
    .clk(clk), .clk_enable(clk_enable),
    .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata),
    .loadEn(loadEn), .loadIndex(loadIndex), .loadWord(loadWord),
    .clearRam(clearRam), .peekAddress(peekAddress), .peekData(peekData)
  );

  // Watchdog over the whole run
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout after %0d cycles, the core never halted", cycleCount);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic word_t xorshift32(word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t signExt(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Two's complement order: a set sign bit marks the smaller value
  function automatic word_t lessSigned(word_t x, word_t y);
    if (x[31] != y[31])
      return {31'b0, x[31]};
    return {31'b0, x < y};
  endfunction

  function automatic word_t lessUnsigned(word_t x, word_t y);
    return {31'b0, x < y};
  endfunction

  // Instruction encoders
  function automatic word_t rType(regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                  logic [4:0] shamt, funct_t fn);
    return {OP_RTYPE, rs, rt, rd, shamt, fn};
  endfunction

  function automatic word_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jType(opcode_t op, logic [25:0] target);
    return {op, target};
  endfunction

  task automatic drawRandom(output word_t r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  task automatic appendWord(int t, word_t w);
    programs[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  // Full 32-bit constant via LUI then ORI
  task automatic loadConstant(int t, regIdx_t r, word_t v);
    appendWord(t, iType(OP_LUI, regZero, r, v[31:16]));
    appendWord(t, iType(OP_ORI, r, r, v[15:0]));
  endtask

  // JR through r0 halts the core
  task automatic endProgram(int t);
    appendWord(t, rType(regZero, regZero, regZero, 5'd0, FN_JR));
  endtask

  task automatic buildArithRow(int t);
    word_t a;
    word_t b;
    word_t e;
    drawRandom(a);
    drawRandom(b);
    loadConstant(t, regT0, a);
    loadConstant(t, regT1, b);
    appendWord(t, rType(regT0, regT1, regV0, 5'd0, FN_ADDU));
    e = a + b;
    appendWord(t, rType(regT0, regT1, regT2, 5'd0, FN_SUBU));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_XOR));
    e = e ^ (a - b);
    appendWord(t, rType(regT0, regT1, regT2, 5'd0, FN_AND));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_ADDU));
    e = e + (a & b);
    appendWord(t, rType(regT0, regT1, regT2, 5'd0, FN_OR));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_SUBU));
    e = e - (a | b);
    appendWord(t, rType(regT0, regT1, regT2, 5'd0, FN_XOR));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_ADDU));
    e = e + (a ^ b);
    endProgram(t);
    expectedV0[t] = e;
  endtask

  task automatic buildCompareRow(int t);
    word_t a;
    word_t b;
    word_t e;
    // Negative a and positive b split signed from unsigned order
    drawRandom(a);
    drawRandom(b);
    a = a | 32'h8000_0000;
    b = b & 32'h7FFF_FFFF;
    loadConstant(t, regT0, a);
    loadConstant(t, regT1, b);
    appendWord(t, rType(regT0, regT1, regV0, 5'd0, FN_SLT));
    e = lessSigned(a, b);
    appendWord(t, rType(regT0, regT1, regT2, 5'd0, FN_SLTU));
    appendWord(t, rType(regZero, regT2, regT2, 5'd1, FN_SLL));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_OR));
    e = e | (lessUnsigned(a, b) << 1);
    appendWord(t, rType(regT1, regT0, regT2, 5'd0, FN_SLT));
    appendWord(t, rType(regZero, regT2, regT2, 5'd2, FN_SLL));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_OR));
    e = e | (lessSigned(b, a) << 2);
    appendWord(t, rType(regT1, regT0, regT2, 5'd0, FN_SLTU));
    appendWord(t, rType(regZero, regT2, regT2, 5'd3, FN_SLL));
    appendWord(t, rType(regV0, regT2, regV0, 5'd0, FN_OR));
    e = e | (lessUnsigned(b, a) << 3);
    endProgram(t);
    expectedV0[t] = e;
  endtask

  task automatic buildImmRow(int t);
    word_t a;
    word_t r;
    word_t e;
    logic [15:0] imm1;
    logic [15:0] imm2;
    logic [15:0] imm3;
    logic [15:0] imm4;
    logic [15:0] imm5;
    drawRandom(a);
    drawRandom(r);
    // Top bit set so sign and zero extension differ
    imm1 = r[15:0] | 16'h8000;
    imm2 = r[31:16] | 16'h8000;
    drawRandom(r);
    imm3 = r[15:0] | 16'h8000;
    imm4 = r[31:16] | 16'h8000;
    drawRandom(r);
    imm5 = r[15:0];
    loadConstant(t, regT0, a);
    appendWord(t, iType(OP_ADDIU, regT0, regV0, imm1));
    e = a + signExt(imm1);
    appendWord(t, iType(OP_ANDI, regT0, regT1, imm2));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_XOR));
    e = e ^ (a & {16'h0000, imm2});
    appendWord(t, iType(OP_ORI, regT0, regT1, imm3));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_ADDU));
    e = e + (a | {16'h0000, imm3});
    appendWord(t, iType(OP_XORI, regT0, regT1, imm4));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_SUBU));
    e = e - (a ^ {16'h0000, imm4});
    appendWord(t, iType(OP_SLTI, regT0, regT1, imm5));
    appendWord(t, rType(regZero, regT1, regT1, 5'd4, FN_SLL));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_ADDU));
    e = e + (lessSigned(a, signExt(imm5)) << 4);
    // Write aimed at r0 reads back as zero
    appendWord(t, iType(OP_ADDIU, regT0, regZero, imm1));
    appendWord(t, rType(regV0, regZero, regV0, 5'd0, FN_ADDU));
    endProgram(t);
    expectedV0[t] = e;
  endtask

  task automatic buildShiftRow(int t);
    word_t a;
    word_t r;
    word_t e;
    logic [4:0] s1;
    logic [4:0] s2;
    logic [4:0] s3;
    drawRandom(a);
    drawRandom(r);
    // Negative operand so SRA fills with ones
    a = a | 32'h8000_0000;
    s1 = r[4:0];
    s2 = r[9:5];
    s3 = r[14:10] | 5'd1;
    loadConstant(t, regT0, a);
    appendWord(t, rType(regZero, regT0, regV0, s1, FN_SLL));
    e = a << s1;
    appendWord(t, rType(regZero, regT0, regT1, s2, FN_SRL));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_XOR));
    e = e ^ (a >> s2);
    appendWord(t, rType(regZero, regT0, regT1, s3, FN_SRA));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_ADDU));
    // Logical shift with the vacated top bits set to the sign
    e = e + ((a >> s3) | ~(32'hFFFF_FFFF >> s3));
    appendWord(t, iType(OP_LUI, regZero, regT1, r[31:16]));
    appendWord(t, rType(regV0, regT1, regV0, 5'd0, FN_XOR));
    e = e ^ {r[31:16], 16'h0000};
    endProgram(t);
    expectedV0[t] = e;
  endtask

  task automatic buildMemRow(int t);
    word_t a;
    word_t b;
    drawRandom(a);
    drawRandom(b);
    loadConstant(t, regT1, a);
    loadConstant(t, regT2, b);
    // Base pointer in the middle of the RAM window
    appendWord(t, iType(OP_ORI, regZero, regT0, 16'h1080));
    // Negative offset lands at 0x107C, positive one at 0x1088
    appendWord(t, iType(OP_SW, regT0, regT1, 16'hFFFC));
    appendWord(t, iType(OP_SW, regT0, regT2, 16'h0008));
    appendWord(t, iType(OP_LW, regT0, regV0, 16'hFFFC));
    appendWord(t, iType(OP_LW, regT0, regT3, 16'h0008));
    appendWord(t, rType(regV0, regT3, regV0, 5'd0, FN_XOR));
    endProgram(t);
    expectedV0[t] = a ^ b;
    ramCheck[t] = 1'b1;
    ramAddr[t] = dataBase + 32'h7C;
    ramValue[t] = a;
  endtask

  task automatic buildBranchRow(int t);
    word_t a;
    word_t target;
    drawRandom(a);
    loadConstant(t, regT0, a);
    appendWord(t, rType(regT0, regZero, regT1, 5'd0, FN_ADDU));
    appendWord(t, iType(OP_ADDIU, regT0, regT2, 16'd1));
    // Word 4 has equal operands and skips word 5
    appendWord(t, iType(OP_BEQ, regT0, regT1, 16'd1));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0001));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0002));
    // Not taken
    appendWord(t, iType(OP_BEQ, regT0, regT2, 16'd1));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0004));
    // Taken over word 10
    appendWord(t, iType(OP_BNE, regT0, regT2, 16'd1));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0008));
    // Not taken
    appendWord(t, iType(OP_BNE, regT0, regT1, 16'd1));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0010));
    // Word 13 jumps to the JR at word 15
    target = `MIPS_RESET_VECTOR + 32'd60;
    appendWord(t, jType(OP_J, target[27:2]));
    appendWord(t, iType(OP_ADDIU, regV0, regV0, 16'h0020));
    endProgram(t);
    // Only the 0x2, 0x4 and 0x10 paths run
    expectedV0[t] = 32'h2 + 32'h4 + 32'h10;
  endtask

  task automatic buildMultRow(int t);
    word_t a;
    word_t b;
    logic [63:0] prod;
    drawRandom(a);
    drawRandom(b);
    // Shift-and-add over the bits of b
    prod = '0;
    for (int i = 0; i < 32; i++)
    begin
      if (b[i])
        prod = prod + ({32'h0, a} << i);
    end
    loadConstant(t, regT0, a);
    loadConstant(t, regT1, b);
    appendWord(t, rType(regT0, regT1, regZero, 5'd0, FN_MULTU));
    appendWord(t, rType(regZero, regZero, regT2, 5'd0, FN_MFLO));
    appendWord(t, rType(regZero, regZero, regV0, 5'd0, FN_MFHI));
    // Low half goes to RAM at the window base
    appendWord(t, iType(OP_ORI, regZero, regT3, dataBase[15:0]));
    appendWord(t, iType(OP_SW, regT3, regT2, 16'h0000));
    endProgram(t);
    expectedV0[t] = prod[63:32];
    ramCheck[t] = 1'b1;
    ramAddr[t] = dataBase;
    ramValue[t] = prod[31:0];
  endtask

  // Same program and expectations, run with a gated clock enable
  task automatic copyStalled(int src, int dst);
    for (int k = 0; k < maxWords; k++)
    begin
      programs[dst][k] = programs[src][k];
    end
    progLen[dst] = progLen[src];
    expectedV0[dst] = expectedV0[src];
    ramCheck[dst] = ramCheck[src];
    ramAddr[dst] = ramAddr[src];
    ramValue[dst] = ramValue[src];
    stallEn[dst] = 1'b1;
  endtask

  task automatic buildTable();
    for (int t = 0; t < numTests; t++)
    begin
      for (int k = 0; k < maxWords; k++)
      begin
        programs[t][k] = '0;
      end
      progLen[t] = 0;
      stallEn[t] = 1'b0;
      ramCheck[t] = 1'b0;
      ramAddr[t] = '0;
      ramValue[t] = '0;
    end
    buildArithRow(0);
    buildCompareRow(1);
    buildImmRow(2);
    buildShiftRow(3);
    buildMemRow(4);
    buildBranchRow(5);
    buildMultRow(6);
    copyStalled(0, 7);
    copyStalled(5, 8);
    copyStalled(6, 9);
  endtask

  task automatic nextEnable(logic stall, output logic en);
    if (stall)
    begin
      rngState = xorshift32(rngState);
      en = rngState[0];
    end
    else
      en = 1'b1;
  endtask

  // Entered and left one ns after a rising edge
  task automatic runTest(int t);
    word_t jrAddr;
    logic  sawJr;
    logic  en;
    reset = 1'b1;
    clk_enable = 1'b0;
    clearRam = 1'b1;
    loadEn = 1'b1;
    // One ROM word per reset cycle
    for (int k = 0; k < resetCycles; k++)
    begin
      loadIndex = 4'(k);
      loadWord = programs[t][k];
      @(posedge clk);
      #1;
    end
    reset = 1'b0;
    clearRam = 1'b0;
    loadEn = 1'b0;
    nextEnable(stallEn[t], en);
    clk_enable = en;
    jrAddr = `MIPS_RESET_VECTOR + 32'(4 * (progLen[t] - 1));
    sawJr = 1'b0;
    while (active)
    begin
      if (instr_address == jrAddr)
        sawJr = 1'b1;
      @(posedge clk);
      #1;
      nextEnable(stallEn[t], en);
      clk_enable = en;
    end

    checkCount++;
    assert (register_v0 == expectedV0[t])
      else
      begin
        errorCount++;
        $display("[FAIL] %0d ns test %0d: register_v0 expected %h, actual %h",
                 $time, t, expectedV0[t], register_v0);
      end
    checkCount++;
    assert (instr_address == `MIPS_HALT_ADDR)
      else
      begin
        errorCount++;
        $display("[FAIL] %0d ns test %0d: instr_address expected %h, actual %h",
                 $time, t, `MIPS_HALT_ADDR, instr_address);
      end
    checkCount++;
    assert (sawJr)
      else
      begin
        errorCount++;
        $display("Test %0d: active fell before the final JR was fetched", t);
      end
    checkCount++;
    assert (!data_write && !data_read)
      else
      begin
        errorCount++;
        $display("Test %0d: data strobes still high after the halt", t);
      end
    if (ramCheck[t])
    begin
      peekAddress = ramAddr[t];
      #1;
      checkCount++;
      assert (peekData == ramValue[t])
        else
        begin
          errorCount++;
          $display("[FAIL] %0d ns test %0d: ram[%h] expected %h, actual %h",
                   $time, t, ramAddr[t], ramValue[t], peekData);
        end
    end
  endtask

  initial
  begin
    reset = 1'b1;
    clk_enable = 1'b0;
    loadEn = 1'b0;
    loadIndex = '0;
    loadWord = '0;
    clearRam = 1'b0;
    peekAddress = '0;
    errorCount = 0;
    checkCount = 0;
    rngState = seed;
    buildTable();
    @(posedge clk);
    #1;
    for (int t = 0; t < numTests; t++)
    begin
      runTest(t);
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mipsCpu.f ====
+incdir+.
mipsPkg.sv
programCounter.sv
controlUnit.sv
registerFile.sv
alu.sv
mipsCpuHarvard.sv
tbMemory.sv
mipsCpuTb.sv

// ==== Makefile ====
# Verilator build and run of the mipsCpu testbench

SOURCES := $(filter-out +%,$(shell cat mipsCpu.f)) mipsCpu_params.svh
BINARY  := obj_dir/VmipsCpuTb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BINARY): mipsCpu.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mipsCpuTb -f mipsCpu.f

run: $(BINARY)
	./$(BINARY) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Failure reported in sim.log"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "No result line in sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
